// ==== vec_video.f ====
src/vec_video_pkg.sv
src/video_strobes.sv
src/video_raster.sv
src/plane_fetch.sv
src/plane_shifter.sv
src/pixel_palette.sv
src/vec_video.sv
testbench/tb_vram_model.sv
testbench/tb_vec_video.sv

// ==== build.sh ====
#!/bin/sh
# compile the vec_video testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vec_video.f \
    --top-module tb_vec_video \
    -o tb_vec_video_sim

# the simulator exits non-zero on failure, so keep its output for the search
out=$(./obj_dir/tb_vec_video_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/tb_vec_video.sv ====
// runs two frames of 6 rows; border_idx is fixed for the run and palette writes come at random gaps
`timescale 1ns/100ps

module tb_vec_video import vec_video_pkg::*; ();

    localparam int line_columns    = 48;
    localparam int frame_rows      = 6;
    localparam int frame_cycles    = frame_rows * line_columns * 32;
    localparam int run_cycles      = 2 * frame_cycles;
    localparam int watchdog_cycles = 3 * frame_cycles;
    // hsync is low for the first 32 pixels of a line
    localparam int sync_px          = 32;
    // border starts at the first reload in sync, one reload per column,
    // and covers 6 more columns after the last one
    localparam int reload_border_px = (sync_px / 8 + 6) * 8;
    // visible window of 32 columns
    localparam int window_px        = 32 * 8;
    // kinds of border-bit runs
    localparam int run_other  = 0;
    localparam int run_reload = 1;
    localparam int run_window = 2;

    logic        clk24;
    logic        reset;
    vram_addr_t  vram_addr;
    logic        vram_rd;
    plane_word_t vram_data;
    color_idx_t  border_idx;
    logic        pal_wr;
    color_idx_t  pal_addr;
    color_t      pal_data;
    pixel_t      pixel;
    logic        pix_strobe;
    logic        hsync;

    // ------------------------------
    // checker state
    // ------------------------------
    color_idx_t exp_q [$];
    color_t     pal_mirror [16];
    // palette as it stood one edge earlier, which is what the DUT captured
    color_t     pal_old [16];
    logic       written [16];
    logic       prev_reset = 1'b0;
    logic       prev_hsync = 1'b0;
    int         row, prev_col, cycles;
    int         lines_seen, reads_in_line, pixels_in_line;
    int         border_pixels, visible_pixels, rewritten_hits;
    logic       have_prev_col;
    // sync width and border runs on the pixel stream
    int         sync_pixels;
    int         run_len;
    int         run_kind;
    int         windows_seen;
    logic       last_border;

    vec_video #(
        .line_columns (line_columns),
        .frame_rows   (frame_rows)
    ) vec_video_inst (
        .clk24      (clk24),
        .reset      (reset),
        .vram_addr  (vram_addr),
        .vram_rd    (vram_rd),
        .vram_data  (vram_data),
        .border_idx (border_idx),
        .pal_wr     (pal_wr),
        .pal_addr   (pal_addr),
        .pal_data   (pal_data),
        .pixel      (pixel),
        .pix_strobe (pix_strobe),
        .hsync      (hsync)
    );

    tb_vram_model tb_vram_model_inst (
        .clk24     (clk24),
        .reset     (reset),
        .vram_addr (vram_addr),
        .vram_rd   (vram_rd),
        .vram_data (vram_data)
    );

    // same memory rule as the model, byte xor plane number times 0x35
    function automatic plane_word_t expected_word(input vram_addr_t addr);
        plane_word_t w;
        w.plane0 = addr[7:0];
        w.plane1 = addr[7:0] ^ 8'h35;
        w.plane2 = addr[7:0] ^ 8'h6a;
        w.plane3 = addr[7:0] ^ 8'h9f;
        return w;
    endfunction

    // plane0 is index bit 3
    function automatic color_idx_t index_at(input plane_word_t w, input int b);
        return {w.plane0[b], w.plane1[b], w.plane2[b], w.plane3[b]};
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // ------------------------------
    // clock and watchdog
    // ------------------------------
    initial begin
        clk24 = 1'b0;
        forever #5 clk24 = ~clk24;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk24);
        $display("watchdog expired, the run did not finish in time");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    // ------------------------------
    // checks on every rising edge
    // ------------------------------
    always @(posedge clk24) begin
        color_idx_t  idx;
        plane_word_t word;
        int          col;
        // outputs must stay quiet in reset and the cycle after
        if (prev_reset) begin
            assert (!vram_rd && !pix_strobe)
                else report_failure("vram_rd or pix_strobe high during or right after reset");
        end
        prev_reset = reset;
        if (reset) begin
            // the bank idle at reset shifts out eight zero pixels first
            exp_q.delete();
            for (int i = 0; i < 8; i++) begin
                exp_q.push_back(4'h0);
            end
            for (int i = 0; i < 16; i++) begin
                pal_mirror[i] = color_t'(i * 17);
                pal_old[i]    = color_t'(i * 17);
                written[i]    = 1'b0;
            end
            prev_hsync    = 1'b0;
            row           = 0;
            cycles        = 0;
            lines_seen    = 0;
            have_prev_col = 1'b0;
            sync_pixels   = 0;
            run_len       = 0;
            run_kind      = run_other;
            last_border   = 1'b0;
        end else begin
            cycles++;
            // line boundary on the falling edge of sync
            if (prev_hsync && !hsync) begin
                if (lines_seen > 0) begin
                    assert (reads_in_line == line_columns)
                        else report_mismatch("reads per line", line_columns, reads_in_line);
                    assert (pixels_in_line == 8 * line_columns)
                        else report_mismatch("pixels per line", 8 * line_columns,
                                             pixels_in_line);
                    assert (sync_pixels == sync_px)
                        else report_mismatch("sync pixels per line", sync_px, sync_pixels);
                end
                lines_seen++;
                reads_in_line  = 0;
                pixels_in_line = 0;
                sync_pixels    = 0;
                row = (row == frame_rows - 1) ? 0 : row + 1;
            end
            prev_hsync = hsync;

            if (vram_rd) begin
                col = int'(vram_addr[12:8]);
                assert (vram_addr[15:13] == 3'b100)
                    else report_mismatch("address page bits", 4, int'(vram_addr[15:13]));
                assert (int'(vram_addr[7:0]) == row / 2)
                    else report_mismatch("address row pair", row / 2, int'(vram_addr[7:0]));
                // next column, or the jump back to 26 on an odd row
                if (have_prev_col) begin
                    assert (col == (prev_col + 1) % 32 || (col == 26 && row % 2 == 1))
                        else report_mismatch("address column", (prev_col + 1) % 32, col);
                end
                prev_col      = col;
                have_prev_col = 1'b1;
                word = expected_word(vram_addr);
                for (int b = 7; b >= 0; b--) begin
                    exp_q.push_back(index_at(word, b));
                end
                assert (exp_q.size() <= 24)
                    else report_failure("reads run ahead of the pixels shown");
                reads_in_line++;
            end

            if (pix_strobe) begin
                assert (exp_q.size() > 0)
                    else report_failure("pixel shown with no fetched word behind it");
                idx = exp_q.pop_front();
                if (pixel.border) begin
                    assert (pixel.color == pal_old[border_idx])
                        else report_mismatch("border colour", int'(pal_old[border_idx]),
                                             int'(pixel.color));
                    border_pixels++;
                end else begin
                    assert (pixel.color == pal_old[idx])
                        else report_mismatch("visible colour", int'(pal_old[idx]),
                                             int'(pixel.color));
                    visible_pixels++;
                    if (written[idx]) begin
                        rewritten_hits++;
                    end
                end
                pixels_in_line++;
                if (!hsync) begin
                    sync_pixels++;
                end
                // a change of the border bit closes the run before it
                if (pixel.border != last_border) begin
                    if (run_kind == run_reload) begin
                        assert (run_len == reload_border_px)
                            else report_mismatch("border after reload",
                                                 reload_border_px, run_len);
                    end
                    if (run_kind == run_window) begin
                        assert (run_len == window_px)
                            else report_mismatch("visible window", window_px, run_len);
                        windows_seen++;
                    end
                    // border rising inside sync on an odd row comes from the reload
                    if (pixel.border && !hsync && row % 2 == 1) begin
                        run_kind = run_reload;
                    end else if (!pixel.border && run_kind == run_reload) begin
                        run_kind = run_window;
                    end else begin
                        run_kind = run_other;
                    end
                    run_len = 0;
                end
                run_len++;
                last_border = pixel.border;
            end

            // mirror follows the DUT palette one edge behind
            pal_old = pal_mirror;
            if (pal_wr) begin
                pal_mirror[pal_addr] = pal_data;
                written[pal_addr]    = 1'b1;
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        int unsigned gap;
        void'($urandom(80900));
        border_pixels  = 0;
        visible_pixels = 0;
        rewritten_hits = 0;
        reads_in_line  = 0;
        pixels_in_line = 0;
        windows_seen   = 0;
        reset      = 1'b1;
        pal_wr     = 1'b0;
        pal_addr   = '0;
        pal_data   = '0;
        border_idx = color_idx_t'($urandom_range(15, 0));
        repeat (2) @(posedge clk24);
        @(negedge clk24);
        reset = 1'b0;
        // random palette writes at random gaps until two frames have gone by
        while (cycles < run_cycles) begin
            gap = $urandom_range(120, 40);
            repeat (gap) @(negedge clk24);
            pal_wr   = 1'b1;
            pal_addr = color_idx_t'($urandom_range(15, 0));
            pal_data = color_t'($urandom());
            @(negedge clk24);
            pal_wr = 1'b0;
        end
        if (border_pixels == 0 || visible_pixels == 0 || windows_seen == 0) begin
            report_failure("run showed no border pixels, no visible pixels or no full window");
        end
        if (rewritten_hits == 0 || lines_seen < 3) begin
            report_failure("run never showed a rewritten entry or too few lines");
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== testbench/tb_vram_model.sv ====
// video memory model; answers each read exactly 4 clocks later and holds the word until the next answer
`timescale 1ns/100ps

module tb_vram_model import vec_video_pkg::*; (
    input  logic        clk24,
    input  logic        reset,
    input  vram_addr_t  vram_addr,
    input  logic        vram_rd,
    output plane_word_t vram_data
);

    // clocks from the read pulse to valid data
    localparam int latency = 4;

    logic [latency-1:0] rd_pipe;
    vram_addr_t         addr_pipe [latency];

    // each plane byte is the low address byte xor plane number times 0x35
    function automatic plane_word_t word_for(input vram_addr_t addr);
        plane_word_t w;
        w.plane0 = addr[7:0];
        w.plane1 = addr[7:0] ^ 8'h35;
        w.plane2 = addr[7:0] ^ 8'h6a;
        w.plane3 = addr[7:0] ^ 8'h9f;
        return w;
    endfunction

    // ------------------------------
    // read delay line
    // ------------------------------
    always_ff @(posedge clk24) begin
        if (reset) begin
            rd_pipe   <= '0;
            vram_data <= '0;
        end else begin
            rd_pipe      <= {rd_pipe[latency-2:0], vram_rd};
            addr_pipe[0] <= vram_addr;
            for (int i = 1; i < latency; i++) begin
                addr_pipe[i] <= addr_pipe[i-1];
            end
            // word appears on the fourth edge after the pulse
            if (rd_pipe[latency-1]) begin
                vram_data <= word_for(addr_pipe[latency-1]);
            end
        end
    end

endmodule

// ==== src/vec_video.sv ====
// video memory must answer each vram_rd within 24 clocks; there is no back-pressure
`timescale 1ns/100ps

module vec_video import vec_video_pkg::*; #(
    parameter int line_columns = 48,
    parameter int frame_rows   = 312
) (
    input  logic        clk24,
    input  logic        reset,
    output vram_addr_t  vram_addr,
    output logic        vram_rd,
    input  plane_word_t vram_data,
    input  color_idx_t  border_idx,
    input  logic        pal_wr,
    input  color_idx_t  pal_addr,
    input  color_t      pal_data,
    output pixel_t      pixel,
    output logic        pix_strobe,
    output logic        hsync
);

    video_strobes_t strobes;
    raster_t        raster;
    logic           load;
    logic           border_flag;
    color_idx_t     color_idx;

    // ------------------------------
    // timing
    // ------------------------------
    video_strobes video_strobes_inst (
        .clk24   (clk24),
        .reset   (reset),
        .strobes (strobes)
    );

    video_raster #(
        .line_columns (line_columns),
        .frame_rows   (frame_rows)
    ) video_raster_inst (
        .clk24   (clk24),
        .reset   (reset),
        .strobes (strobes),
        .raster  (raster)
    );

    // ------------------------------
    // fetch, shift and palette
    // ------------------------------
    plane_fetch plane_fetch_inst (
        .clk24       (clk24),
        .reset       (reset),
        .strobes     (strobes),
        .raster      (raster),
        .vram_addr   (vram_addr),
        .vram_rd     (vram_rd),
        .load        (load),
        .border_flag (border_flag)
    );

    plane_shifter plane_shifter_inst (
        .clk24     (clk24),
        .reset     (reset),
        .strobes   (strobes),
        .load      (load),
        .vram_data (vram_data),
        .color_idx (color_idx)
    );

    pixel_palette pixel_palette_inst (
        .clk24       (clk24),
        .reset       (reset),
        .strobes     (strobes),
        .color_idx   (color_idx),
        .border_flag (border_flag),
        .border_idx  (border_idx),
        .pal_wr      (pal_wr),
        .pal_addr    (pal_addr),
        .pal_data    (pal_data),
        .pixel       (pixel),
        .pix_strobe  (pix_strobe)
    );

    // line sync straight from the raster counter
    assign hsync = raster.hsync;

endmodule

// ==== src/pixel_palette.sv ====
// a palette write and a lookup of the same entry on one clock return the old colour
`timescale 1ns/100ps

module pixel_palette import vec_video_pkg::*; (
    input  logic           clk24,
    input  logic           reset,
    input  video_strobes_t strobes,
    input  color_idx_t     color_idx,
    input  logic           border_flag,
    input  color_idx_t     border_idx,
    input  logic           pal_wr,
    input  color_idx_t     pal_addr,
    input  color_t         pal_data,
    output pixel_t         pixel,
    output logic           pix_strobe
);

    // 16 entries of bbgggrrr
    color_t     pal [16];
    color_idx_t lookup_idx;

    // ------------------------------
    // palette register file
    // ------------------------------
    // reset value is a grey-ish ramp, entry i = i * 17
    always_ff @(posedge clk24) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                pal[i] <= color_t'(i * 17);
            end
        end else if (pal_wr) begin
            pal[pal_addr] <= pal_data;
        end
    end

    // border colour replaces the plane index while border is up
    assign lookup_idx = border_flag ? border_idx : color_idx;

    // ------------------------------
    // output register
    // ------------------------------
    // colour and border bit are captured once per pixel
    always_ff @(posedge clk24) begin
        if (strobes.ce_pixel) begin
            pixel.color  <= pal[lookup_idx];
            pixel.border <= border_flag;
        end
    end

    // strobe marks the clock after each capture
    always_ff @(posedge clk24) begin
        if (reset) begin
            pix_strobe <= 1'b0;
        end else begin
            pix_strobe <= strobes.ce_pixel;
        end
    end

endmodule

// ==== src/plane_shifter.sv ====
// a load must arrive while its bank is idle; no check is made that a bank was loaded before it shifts
`timescale 1ns/100ps

module plane_shifter import vec_video_pkg::*; (
    input  logic           clk24,
    input  logic           reset,
    input  video_strobes_t strobes,
    input  logic           load,
    input  plane_word_t    vram_data,
    output color_idx_t     color_idx
);

    // two banks of four plane bytes
    plane_word_t bank_a;
    plane_word_t bank_b;
    plane_word_t active;

    // shift each plane one bit towards the MSB, zero fill
    function automatic plane_word_t shift_word(input plane_word_t w);
        plane_word_t r;
        r.plane0 = {w.plane0[6:0], 1'b0};
        r.plane1 = {w.plane1[6:0], 1'b0};
        r.plane2 = {w.plane2[6:0], 1'b0};
        r.plane3 = {w.plane3[6:0], 1'b0};
        return r;
    endfunction

    // ------------------------------
    // ping-pong banks
    // ------------------------------
    // pipe_abx high: bank b shifts, bank a takes the load
    // pipe_abx low:  bank a shifts, bank b takes the load
    always_ff @(posedge clk24) begin
        if (reset) begin
            bank_a <= '0;
            bank_b <= '0;
        end else if (strobes.pipe_abx) begin
            if (load) begin
                bank_a <= vram_data;
            end
            if (strobes.ce_pixel) begin
                bank_b <= shift_word(bank_b);
            end
        end else begin
            if (load) begin
                bank_b <= vram_data;
            end
            if (strobes.ce_pixel) begin
                bank_a <= shift_word(bank_a);
            end
        end
    end

    assign active = strobes.pipe_abx ? bank_b : bank_a;

    // current pixel is the MSB of each plane, plane0 is index bit 3
    assign color_idx = {active.plane0[7], active.plane1[7],
                        active.plane2[7], active.plane3[7]};

endmodule

// ==== src/plane_fetch.sv ====
// read data must be valid on vram_data by the slot 3 slice, 24 clocks after the vram_rd pulse
`timescale 1ns/100ps

module plane_fetch import vec_video_pkg::*; (
    input  logic           clk24,
    input  logic           reset,
    input  video_strobes_t strobes,
    input  raster_t        raster,
    output vram_addr_t     vram_addr,
    output logic           vram_rd,
    output logic           load,
    output logic           border_flag
);

    // slot 26 is where the visible window starts after a reload
    localparam logic [col_w-1:0] reload_col = col_w'(26);

    // slot within a column, advances once per slice
    logic [1:0]       slot;
    logic [col_w-1:0] column;
    // border level before the pixel pipeline delay
    logic             border_q;
    // two pixel times of delay to line up with the shifter output
    logic [1:0]       border_dly;
    logic             slice_en;

    // ce12 that precedes a ce_pixel inside the slice window
    assign slice_en = strobes.video_slice & strobes.ce12 & ~strobes.ce_pixel;

    // ------------------------------
    // column and slot sequencing
    // ------------------------------
    always_ff @(posedge clk24) begin
        if (reset) begin
            slot     <= '0;
            column   <= '0;
            border_q <= 1'b0;
            vram_rd  <= 1'b0;
            load     <= 1'b0;
        end else if (slice_en) begin
            if (slot == 2'd3) begin
                // odd row in sync, jump back to column 26 inside the border
                if (!raster.hsync && raster.fb_row[0]) begin
                    column   <= reload_col;
                    border_q <= 1'b1;
                end else begin
                    column <= column + 1'b1;
                end
                // wrapping to column 0 flips border on or off
                if (column == '0) begin
                    border_q <= ~border_q;
                end
            end
            slot    <= slot + 1'b1;
            // read request at slot 0, shifter load at slot 3
            vram_rd <= (slot == 2'd0);
            load    <= (slot == 2'd3);
        end else begin
            vram_rd <= 1'b0;
            load    <= 1'b0;
        end
    end

    // address refreshed on every slice from the current column
    // and the row pair, top bit marks the video page
    always_ff @(posedge clk24) begin
        if (slice_en) begin
            vram_addr <= {1'b1, 2'b00, column, raster.fb_row[row_w-1:1]};
        end
    end

    // ------------------------------
    // border delay
    // ------------------------------
    always_ff @(posedge clk24) begin
        if (reset) begin
            border_dly <= '0;
        end else if (strobes.ce_pixel) begin
            border_dly <= {border_q, border_dly[1]};
        end
    end

    assign border_flag = border_dly[0];

endmodule

// ==== src/video_raster.sv ====
// line_columns must be at least 5 so the 32-pixel sync window fits in a line
`timescale 1ns/100ps

module video_raster import vec_video_pkg::*; #(
    parameter int line_columns = 48,
    parameter int frame_rows   = 312
) (
    input  logic           clk24,
    input  logic           reset,
    input  video_strobes_t strobes,
    output raster_t        raster
);

    // pixels per line and the counter width to hold them
    localparam int px_total = 8 * line_columns;
    localparam int px_w     = $clog2(px_total);
    // sync spans the first 32 pixels of every line
    localparam int sync_px  = 32;

    logic [px_w-1:0] pix_cnt;
    logic            line_end;

    // last pixel of the line
    assign line_end = (pix_cnt == px_w'(px_total - 1));

    // ------------------------------
    // pixel and row counters
    // ------------------------------
    // hsync is registered next to the counters, so the row
    // number and the falling edge of sync move together
    always_ff @(posedge clk24) begin
        if (reset) begin
            pix_cnt       <= '0;
            raster.fb_row <= '0;
            raster.hsync  <= 1'b0;
        end else if (strobes.ce_pixel) begin
            if (line_end) begin
                pix_cnt      <= '0;
                // new line opens with sync active
                raster.hsync <= 1'b0;
                if (raster.fb_row == row_w'(frame_rows - 1)) begin
                    raster.fb_row <= '0;
                end else begin
                    raster.fb_row <= raster.fb_row + 1'b1;
                end
            end else begin
                pix_cnt      <= pix_cnt + 1'b1;
                // release sync once the count reaches 32
                raster.hsync <= (pix_cnt >= px_w'(sync_px - 1));
            end
        end
    end

endmodule

// ==== src/video_strobes.sv ====
// strobes are registered and lag the phase counter by one clock; all of them are low during reset
`timescale 1ns/100ps

module video_strobes import vec_video_pkg::*; (
    input  logic           clk24,
    input  logic           reset,
    output video_strobes_t strobes
);

    // free-running phase, one byte column every 32 clocks
    logic [phase_w-1:0] phase;
    logic               abx;

    // ------------------------------
    // phase counter
    // ------------------------------
    always_ff @(posedge clk24) begin
        if (reset) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // ------------------------------
    // strobe decode
    // ------------------------------
    // decoded from the registered phase and registered once more,
    // so every strobe switches on the same edge
    always_ff @(posedge clk24) begin
        if (reset) begin
            strobes <= '0;
            abx     <= 1'b0;
        end else begin
            // 12 MHz on even phases
            strobes.ce12        <= ~phase[0];
            // 6 MHz pixel enable, phases 0 mod 4
            strobes.ce_pixel    <= (phase[1:0] == 2'b00);
            // memory slice window, phases 2 and 3 mod 8
            strobes.video_slice <= (phase[2:1] == 2'b01);
            // ping-pong bank select flips once per column
            if (phase == '0) begin
                abx <= ~abx;
            end
            strobes.pipe_abx    <= (phase == '0) ? ~abx : abx;
        end
    end

endmodule

// ==== src/vec_video_pkg.sv ====
// shared video types; plane0 sits in the low byte of a read word and drives index bit 3
package vec_video_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // phase counter spans one 8-pixel column at 4 clocks per pixel
    localparam int phase_w = 5;
    // byte column within a line, 32 columns of video memory
    localparam int col_w   = 5;
    // frame row, up to 512 rows
    localparam int row_w   = 9;

    // word address: 1, 00, column[4:0], row pair[7:0]
    typedef logic [15:0] vram_addr_t;

    // one 32-bit read covers all four planes at a single address
    typedef struct packed {
        logic [7:0] plane3;
        logic [7:0] plane2;
        logic [7:0] plane1;
        logic [7:0] plane0;
    } plane_word_t;

    typedef struct packed {
        logic ce12;
        logic ce_pixel;
        logic video_slice;
        logic pipe_abx;
    } video_strobes_t;

    // hsync is active low, during the first 32 pixels of a line
    typedef struct packed {
        logic [row_w-1:0] fb_row;
        logic             hsync;
    } raster_t;

    typedef logic [3:0] color_idx_t;
    // bbgggrrr
    typedef logic [7:0] color_t;

    typedef struct packed {
        color_t color;
        logic   border;
    } pixel_t;

endpackage
